/* hdl/cas_ctrl.sv */
// ======================================================================
// Cassette player control and DDR3 read port sharing
// Playback is armed once a CAS download has finished, until reset
// The ROM loader always wins the DDR3 port while dl_request is high
// Requests are not stored, each requester holds its own until ready
// ======================================================================
`timescale 1ns/100ps
`include "msx_params.svh"

module cas_ctrl
   import msx_media_pkg::*;
(
   input  logic        clk21m,
   input  logic        rst,
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic        tape_rewind_req,
   input  logic        motor,
   input  cas_src_e    cas_src,
   input  logic        cas_dout,
   input  logic        adc_dout,
   input  logic        adc_active,
   input  ddr_rd_req_t ddr_dl,
   input  logic        dl_request,
   input  ddr_rd_req_t ddr_cas,
   output logic        cas_audio,
   output logic        play,
   output logic        rewind,
   output ddr_rd_req_t ddr_req
);

   logic is_cas;
   logic is_cas_last;
   logic cas_loaded;

   // ======================================================================
   // CAS load tracking
   // ======================================================================
   // Only the low 6 bits of the index name the slot
   assign is_cas = ioctl_download &&
                   (ioctl_index[5:0] == 6'(`MSX_CAS_INDEX));

   always_ff @(posedge clk21m) begin
      if (rst) begin
         is_cas_last <= 1'b0;
         cas_loaded  <= 1'b0;
      end else begin
         is_cas_last <= is_cas;
         // Falling edge of the download
         if (is_cas_last && !is_cas)
            cas_loaded <= 1'b1;
      end
   end

   // Tape runs while the motor relay line is low
   assign play = ~motor & cas_loaded;

   // New file or reset restarts the tape from the top
   assign rewind = tape_rewind_req | is_cas | rst;

   // Tape input, ADC bit only counts while the receiver has a signal
   assign cas_audio = (cas_src == CAS_SRC_FILE) ? cas_dout
                                                 : (adc_active & adc_dout);

   // ======================================================================
   // DDR3 read port
   // ======================================================================
   always_comb begin
      if (dl_request)
         ddr_req = ddr_dl;
      else
         ddr_req = ddr_cas;
   end

endmodule

/* hdl/msx_glue_top.sv */
// ======================================================================
// MSX top level glue: video settings, SD routing and cassette control
// All blocks run on clk21m with a synchronous active high reset
// ddr_ready is fanned out unchanged to both DDR3 requesters
// ======================================================================
`timescale 1ns/100ps
`include "msx_params.svh"

module msx_glue_top
   import msx_video_pkg::*;
   import msx_media_pkg::*;
#(
   parameter int ACT_TIMEOUT = `MSX_SD_ACT_TIMEOUT
) (
   input  logic                  clk21m,
   input  logic                  rst,
   // Video
   input  video_settings_t       video_settings,
   input  logic                  forced_scandoubler,
   input  logic [`MSX_DIM_W-1:0] hdmi_width,
   input  logic [`MSX_DIM_W-1:0] hdmi_height,
   output video_result_t         video_result,
   // SD card
   input  spi_master_t           spi_master,
   input  logic                  sd_miso,
   input  logic                  vsd_miso,
   input  logic                  vsd_mounted,
   input  logic [63:0]           vsd_size,
   output logic                  sd_miso_core,
   output sd_pins_t              sd_pins,
   output logic                  led_user,
   output logic [1:0]            led_disk,
   // Cassette
   input  logic                  ioctl_download,
   input  logic [15:0]           ioctl_index,
   input  logic                  tape_rewind_req,
   input  logic                  motor,
   input  cas_src_e              cas_src,
   input  logic                  cas_dout,
   input  logic                  adc_dout,
   input  logic                  adc_active,
   output logic                  cas_audio,
   output logic                  play,
   output logic                  rewind,
   // DDR3 read port
   input  ddr_rd_req_t           ddr_dl,
   input  logic                  dl_request,
   input  ddr_rd_req_t           ddr_cas,
   input  logic                  ddr_ready,
   output ddr_rd_req_t           ddr_req,
   output logic                  dl_ready,
   output logic                  cas_ready
);

   video_crop_ctrl u_video (
      .clk21m             (clk21m),
      .rst                (rst),
      .video_settings     (video_settings),
      .forced_scandoubler (forced_scandoubler),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .video_result       (video_result)
   );

   sd_route #(
      .ACT_TIMEOUT (ACT_TIMEOUT)
   ) u_sd (
      .clk21m       (clk21m),
      .rst          (rst),
      .spi_master   (spi_master),
      .sd_miso      (sd_miso),
      .vsd_miso     (vsd_miso),
      .vsd_mounted  (vsd_mounted),
      .vsd_size     (vsd_size),
      .sd_miso_core (sd_miso_core),
      .sd_pins      (sd_pins),
      .led_user     (led_user),
      .led_disk     (led_disk)
   );

   cas_ctrl u_cas (
      .clk21m          (clk21m),
      .rst             (rst),
      .ioctl_download  (ioctl_download),
      .ioctl_index     (ioctl_index),
      .tape_rewind_req (tape_rewind_req),
      .motor           (motor),
      .cas_src         (cas_src),
      .cas_dout        (cas_dout),
      .adc_dout        (adc_dout),
      .adc_active      (adc_active),
      .ddr_dl          (ddr_dl),
      .dl_request      (dl_request),
      .ddr_cas         (ddr_cas),
      .cas_audio       (cas_audio),
      .play            (play),
      .rewind          (rewind),
      .ddr_req         (ddr_req)
   );

   // Both requesters watch the same ready, only the granted one acts on it
   assign dl_ready  = ddr_ready;
   assign cas_ready = ddr_ready;

endmodule

/* hdl/msx_media_pkg.sv */
// ======================================================================
// SD card, DDR3 read port and tape source types
// A DDR3 requester holds addr and rd until the memory answers ready
// ======================================================================
`include "msx_params.svh"

package msx_media_pkg;

   // Lines toward the physical card slot
   typedef struct packed {
      logic sck;
      logic mosi;
      logic cs;
   } sd_pins_t;

   // Outputs of the SPI master
   typedef struct packed {
      logic sclk;
      logic mosi;
   } spi_master_t;

   // One read request on the shared DDR3 port
   typedef struct packed {
      logic [`MSX_DDR_ADDR_W-1:0] addr;
      // Read strobe
      logic                       rd;
   } ddr_rd_req_t;

   // Tape audio input
   typedef enum logic {
      CAS_SRC_FILE = 1'b0,
      CAS_SRC_ADC  = 1'b1
   } cas_src_e;

endpackage

/* hdl/msx_params.svh */
// ======================================================================
// Shared widths and constants for the MSX glue logic
// All counts are in clk21m cycles
// Aspect values are the words handed to the scaler, not pixel sizes
// ======================================================================
`ifndef MSX_PARAMS_SVH
`define MSX_PARAMS_SVH

// HDMI dimension and crop size width
`define MSX_DIM_W 12
// Aspect word width
`define MSX_AR_W 12
// DDR3 byte address
`define MSX_DDR_ADDR_W 28

// SD activity hold, about 47 ms at 21.48 MHz
`define MSX_SD_ACT_TIMEOUT 1000000

// Host download slot of a CAS file
`define MSX_CAS_INDEX 5

// Aspect words for the stretched modes
`define MSX_AR_X_NORMAL 400
`define MSX_AR_X_WIDE 340
`define MSX_AR_Y 300

`endif

/* hdl/msx_video_pkg.sv */
// ======================================================================
// Video settings and scaler result types
// Field order of both structs is fixed, the top level and the testbench
// build them by name only
// ======================================================================
`include "msx_params.svh"

package msx_video_pkg;

   // On-screen video options
   typedef struct packed {
      // 0 is original, nonzero stretches
      logic [1:0] ar;
      // 0 none, 1..2 HQ2x, 3..5 scanlines
      logic [2:0] fx;
      logic [1:0] scale;
      logic       vcrop_en;
   } video_settings_t;

   // Values for the scaler and the video mixer
   typedef struct packed {
      logic [`MSX_AR_W-1:0]  arx;
      logic [`MSX_AR_W-1:0]  ary;
      logic [`MSX_DIM_W-1:0] crop_size;
      logic [2:0]            scale;
      // Scanline level
      logic [1:0]            sl;
      logic                  hq2x;
      logic                  scandoubler;
   } video_result_t;

endpackage

/* hdl/sd_route.sv */
// ======================================================================
// SD card routing between the slot and the virtual SD image
// Virtual SD is picked when an image with nonzero size is mounted
// LEDs stay lit ACT_TIMEOUT cycles after the last SPI data toggle
// ======================================================================
`timescale 1ns/100ps
`include "msx_params.svh"

module sd_route
   import msx_media_pkg::*;
#(
   parameter int ACT_TIMEOUT = `MSX_SD_ACT_TIMEOUT
) (
   input  logic        clk21m,
   input  logic        rst,
   input  spi_master_t spi_master,
   input  logic        sd_miso,
   input  logic        vsd_miso,
   input  logic        vsd_mounted,
   input  logic [63:0] vsd_size,
   output logic        sd_miso_core,
   output sd_pins_t    sd_pins,
   output logic        led_user,
   output logic [1:0]  led_disk
);

   localparam int CNT_W = $clog2(ACT_TIMEOUT + 1);

   logic             vsd_sel;
   logic             old_mosi;
   logic             old_miso;
   logic             sd_act;
   logic [CNT_W-1:0] act_cnt;

   always_ff @(posedge clk21m) begin
      if (rst)
         vsd_sel <= 1'b0;
      else if (vsd_mounted)
         vsd_sel <= |vsd_size;
   end

   // Card pins idle while the image is in use
   assign sd_pins.cs   = vsd_sel;
   assign sd_pins.sck  = spi_master.sclk & ~vsd_sel;
   assign sd_pins.mosi = spi_master.mosi & ~vsd_sel;
   assign sd_miso_core = vsd_sel ? vsd_miso : sd_miso;

   // ======================================================================
   // Activity timer
   // ======================================================================
   // Line history for edge detection, sampled during reset as well
   always_ff @(posedge clk21m) begin
      old_mosi <= spi_master.mosi;
      old_miso <= sd_miso_core;
   end

   always_ff @(posedge clk21m) begin
      if (rst) begin
         act_cnt <= CNT_W'(ACT_TIMEOUT);
         sd_act  <= 1'b0;
      end else begin
         sd_act <= act_cnt < CNT_W'(ACT_TIMEOUT);
         if ((old_mosi ^ spi_master.mosi) || (old_miso ^ sd_miso_core))
            act_cnt <= '0;
         else if (act_cnt < CNT_W'(ACT_TIMEOUT))
            act_cnt <= act_cnt + 1'b1;
      end
   end

   // Bit 1 set hands the disk LED fully to bit 0
   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

/* hdl/video_crop_ctrl.sv */
// ======================================================================
// Scaler settings from the video options and the HDMI mode
// Crop and wide flag lag the inputs by one clock
// Crop is only found for the common HDMI heights, anything else gives 0
// ======================================================================
`timescale 1ns/100ps
`include "msx_params.svh"

module video_crop_ctrl
   import msx_video_pkg::*;
(
   input  logic                  clk21m,
   input  logic                  rst,
   input  video_settings_t       video_settings,
   input  logic                  forced_scandoubler,
   input  logic [`MSX_DIM_W-1:0] hdmi_width,
   input  logic [`MSX_DIM_W-1:0] hdmi_height,
   output video_result_t         video_result
);

   logic [`MSX_DIM_W-1:0] vcrop;
   logic                  wide;
   logic                  scandoubler;
   logic                  landscape;

   assign scandoubler = (video_settings.fx != 3'd0) || forced_scandoubler;

   // Width at least 1.5 times height, one extra bit so the sum cannot wrap
   assign landscape = {1'b0, hdmi_width} >=
                      ({1'b0, hdmi_height} + {2'b00, hdmi_height[`MSX_DIM_W-1:1]});

   // ======================================================================
   // Crop lookup
   // ======================================================================
   always_ff @(posedge clk21m) begin
      if (rst) begin
         vcrop <= '0;
         wide  <= 1'b0;
      end else begin
         vcrop <= '0;
         wide  <= 1'b0;
         if (landscape && !scandoubler) begin
            case (hdmi_height)
               `MSX_DIM_W'd480,
               `MSX_DIM_W'd720,
               `MSX_DIM_W'd1200: vcrop <= `MSX_DIM_W'd240;
               `MSX_DIM_W'd600,
               `MSX_DIM_W'd800: begin
                  vcrop <= `MSX_DIM_W'd200;
                  // 200 lines need the narrower aspect to keep 4:3
                  wide  <= video_settings.vcrop_en;
               end
               // NTSC only shows about 250 of these lines
               `MSX_DIM_W'd768:  vcrop <= `MSX_DIM_W'd256;
               `MSX_DIM_W'd1080: vcrop <= `MSX_DIM_W'd216;
               default: vcrop <= '0;
            endcase
         end else if (hdmi_width >= `MSX_DIM_W'd1440 && !scandoubler) begin
            // 4:3 panels miss the landscape test above
            case (hdmi_height)
               `MSX_DIM_W'd1440: vcrop <= `MSX_DIM_W'd240;
               `MSX_DIM_W'd1536: vcrop <= `MSX_DIM_W'd256;
               default: vcrop <= '0;
            endcase
         end
      end
   end

   // ======================================================================
   // Scaler and mixer fields
   // ======================================================================
   always_comb begin
      if (video_settings.ar != 2'd0) begin
         video_result.arx = wide ? `MSX_AR_W'(`MSX_AR_X_WIDE) :
                                   `MSX_AR_W'(`MSX_AR_X_NORMAL);
         video_result.ary = `MSX_AR_W'(`MSX_AR_Y);
      end else begin
         // Original mode, low bits pick the scaler's built-in ratio
         video_result.arx = {{(`MSX_AR_W-2){1'b0}}, video_settings.ar - 2'd1};
         video_result.ary = '0;
      end

      video_result.crop_size   = video_settings.vcrop_en ? vcrop : '0;
      video_result.scale       = {1'b0, video_settings.scale};
      video_result.scandoubler = scandoubler;

      // Scanlines for fx 3 and up
      if (video_settings.fx > 3'd2)
         video_result.sl = 2'(video_settings.fx - 3'd2);
      else
         video_result.sl = 2'd0;

      // HQ2x for fx 1 and 2
      video_result.hq2x = ~video_settings.fx[2] &
                          (video_settings.fx[1] ^ video_settings.fx[0]);
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the MSX glue testbench with Verilator
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
   --top-module tb_msx_glue -Mdir obj_dir -f vlog.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/Vtb_msx_glue
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi

exit 0

/* tests/tb_msx_glue.sv */
// ======================================================================
// Directed testbench for the MSX glue top level
// SD activity timeout is cut to 64 cycles so the LED tests stay short
// Inputs change on the falling edge, the run stops at the first mismatch
// ======================================================================
`timescale 1ns/100ps
`include "msx_params.svh"

module tb_msx_glue
   import msx_video_pkg::*;
   import msx_media_pkg::*;
();

   localparam int ACT_TIMEOUT = 64;
   // Tests take roughly 600 cycles, limit leaves a wide margin
   localparam int TIMEOUT_CYCLES = 2000;

   // HDMI modes for the crop table
   localparam int N_MODES = 11;
   localparam int MODE_W [N_MODES] = '{720, 1280, 1920, 1024, 1280, 1366, 1920,
                                       1920, 2048, 1440, 640};
   localparam int MODE_H [N_MODES] = '{480, 720, 1200, 600, 800, 768, 1080,
                                       1440, 1536, 1080, 480};

   logic                  clk21m;
   logic                  rst;
   video_settings_t       video_settings;
   logic                  forced_scandoubler;
   logic [`MSX_DIM_W-1:0] hdmi_width;
   logic [`MSX_DIM_W-1:0] hdmi_height;
   video_result_t         video_result;
   spi_master_t           spi_master;
   logic                  sd_miso;
   logic                  vsd_miso;
   logic                  vsd_mounted;
   logic [63:0]           vsd_size;
   logic                  sd_miso_core;
   sd_pins_t              sd_pins;
   logic                  led_user;
   logic [1:0]            led_disk;
   logic                  ioctl_download;
   logic [15:0]           ioctl_index;
   logic                  tape_rewind_req;
   logic                  motor;
   cas_src_e              cas_src;
   logic                  cas_dout;
   logic                  adc_dout;
   logic                  adc_active;
   logic                  cas_audio;
   logic                  play;
   logic                  rewind;
   ddr_rd_req_t           ddr_dl;
   logic                  dl_request;
   ddr_rd_req_t           ddr_cas;
   logic                  ddr_ready;
   ddr_rd_req_t           ddr_req;
   logic                  dl_ready;
   logic                  cas_ready;

   int          cycle_cnt = 0;
   logic [31:0] lfsr_state = 32'h2ede0d21;

   msx_glue_top #(
      .ACT_TIMEOUT (ACT_TIMEOUT)
   ) dut0 (.*);

   initial begin
      clk21m = 1'b0;
      forever #20 clk21m = ~clk21m;
   end

   always @(posedge clk21m) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("TEST RESULT: FAIL");
         $fatal(1, "Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      end
   end

   // ======================================================================
   // Helpers
   // ======================================================================
   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic next_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [63:0] rand_value(input int nbits);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < nbits; i++)
         v = {v[62:0], next_bit()};
      return v;
   endfunction

   task automatic check(input string name, input logic [63:0] actual,
                        input logic [63:0] expected);
      if (actual !== expected) begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   task automatic next_cycles(input int n);
      repeat (n) @(negedge clk21m);
   endtask

   // Expected crop for a mode, scandoubler active forces 0
   function automatic int model_crop(input int w, input int h, input logic sd);
      if (sd)
         return 0;
      if (w >= h + h / 2) begin
         case (h)
            480, 720, 1200: return 240;
            600, 800:       return 200;
            768:            return 256;
            1080:           return 216;
            default:        return 0;
         endcase
      end
      if (w >= 1440) begin
         case (h)
            1440:    return 240;
            1536:    return 256;
            default: return 0;
         endcase
      end
      return 0;
   endfunction

   task automatic mount_image(input logic [63:0] size);
      @(negedge clk21m);
      vsd_size    = size;
      vsd_mounted = 1'b1;
      @(negedge clk21m);
      vsd_mounted = 1'b0;
   endtask

   // All SPI line combinations against the expected routing
   task automatic check_sd_pins(input logic virt);
      for (int i = 0; i < 8; i++) begin
         @(negedge clk21m);
         spi_master.sclk = i[0];
         spi_master.mosi = i[1];
         sd_miso         = i[2];
         vsd_miso        = ~i[2];
         #5;
         check("sd_pins.cs", 64'(sd_pins.cs), 64'(virt));
         check("sd_pins.sck", 64'(sd_pins.sck), virt ? 64'd0 : 64'(i[0]));
         check("sd_pins.mosi", 64'(sd_pins.mosi), virt ? 64'd0 : 64'(i[1]));
         check("sd_miso_core", 64'(sd_miso_core), virt ? 64'(!i[2]) : 64'(i[2]));
      end
   endtask

   task automatic check_leds(input logic virt, input logic on);
      check("led_user", 64'(led_user), 64'(virt & on));
      check("led_disk", 64'(led_disk), 64'({1'b1, ~virt & on}));
   endtask

   task automatic run_download(input logic [15:0] index, input logic is_cas);
      @(negedge clk21m);
      ioctl_index    = index;
      ioctl_download = 1'b1;
      repeat (4) begin
         @(negedge clk21m);
         check("rewind", 64'(rewind), 64'(is_cas));
      end
      ioctl_download = 1'b0;
      next_cycles(2);
   endtask

   // ======================================================================
   // Directed tests
   // ======================================================================
   task automatic test_cassette();
      @(negedge clk21m);
      #5;
      check("play", 64'(play), 64'd0);
      check("rewind", 64'(rewind), 64'd0);
      tape_rewind_req = 1'b1;
      #5;
      check("rewind", 64'(rewind), 64'd1);
      @(negedge clk21m);
      tape_rewind_req = 1'b0;
      run_download(16'h0003, 1'b0);
      check("play", 64'(play), 64'd0);
      // Upper index bits are not part of the slot number
      run_download(16'h0105, 1'b1);
      check("play", 64'(play), 64'd1);
      motor = 1'b1;
      #5;
      check("play", 64'(play), 64'd0);
      motor = 1'b0;
   endtask

   task automatic test_crop_table();
      int crop;
      for (int m = 0; m < N_MODES; m++) begin
         // v 0 plain, 1 crop off, 2 fx set, 3 forced scandoubler
         for (int v = 0; v < 4; v++) begin
            @(negedge clk21m);
            hdmi_width              = 12'(MODE_W[m]);
            hdmi_height             = 12'(MODE_H[m]);
            video_settings.ar       = 2'd1;
            video_settings.fx       = (v == 2) ? 3'd3 : 3'd0;
            video_settings.vcrop_en = (v != 1);
            forced_scandoubler      = (v == 3);
            next_cycles(2);
            crop = model_crop(MODE_W[m], MODE_H[m], v >= 2);
            check("crop_size", 64'(video_result.crop_size), (v == 1) ? 64'd0 : 64'(crop));
            check("arx", 64'(video_result.arx), (crop == 200 && v != 1) ?
                  64'(`MSX_AR_X_WIDE) : 64'(`MSX_AR_X_NORMAL));
         end
      end
   endtask

   task automatic test_aspect_fields();
      logic [1:0] scale;
      int         exp_sl;
      // Mode without crop keeps the wide flag clear
      @(negedge clk21m);
      hdmi_width              = 12'd640;
      hdmi_height             = 12'd480;
      video_settings.vcrop_en = 1'b0;
      next_cycles(2);
      for (int a = 0; a < 4; a++) begin
         for (int f = 0; f < 8; f++) begin
            for (int fs = 0; fs < 2; fs++) begin
               @(negedge clk21m);
               scale                = 2'(rand_value(2));
               video_settings.ar    = 2'(a);
               video_settings.fx    = 3'(f);
               video_settings.scale = scale;
               forced_scandoubler   = (fs == 1);
               #5;
               // sl field is only 2 bits wide
               exp_sl = (f > 2) ? (f - 2) % 4 : 0;
               check("arx", 64'(video_result.arx), (a != 0) ? 64'(`MSX_AR_X_NORMAL) : 64'd3);
               check("ary", 64'(video_result.ary), (a != 0) ? 64'(`MSX_AR_Y) : 64'd0);
               check("sl", 64'(video_result.sl), 64'(exp_sl));
               check("hq2x", 64'(video_result.hq2x), (f == 1 || f == 2) ? 64'd1 : 64'd0);
               check("scandoubler", 64'(video_result.scandoubler),
                     (f != 0 || fs == 1) ? 64'd1 : 64'd0);
               check("scale", 64'(video_result.scale), 64'(scale));
            end
         end
      end
   endtask

   task automatic test_sd_routing();
      logic [63:0] size;
      check_sd_pins(1'b0);
      size = rand_value(64);
      if (size == 64'd0)
         size = 64'd1;
      mount_image(size);
      check_sd_pins(1'b1);
      mount_image(64'd0);
      check_sd_pins(1'b0);
   endtask

   task automatic test_activity_led(input logic virt);
      mount_image(virt ? (rand_value(32) | 64'd1) : 64'd0);
      @(negedge clk21m);
      spi_master = '0;
      sd_miso    = 1'b0;
      vsd_miso   = 1'b0;
      // Let earlier line changes time out
      next_cycles(ACT_TIMEOUT + 16);
      check_leds(virt, 1'b0);
      @(negedge clk21m);
      spi_master.mosi = 1'b1;
      next_cycles(3);
      check_leds(virt, 1'b1);
      next_cycles(57);
      check_leds(virt, 1'b1);
      next_cycles(10);
      check_leds(virt, 1'b0);
      // Only the selected card's MISO counts as activity
      @(negedge clk21m);
      if (virt)
         sd_miso = 1'b1;
      else
         vsd_miso = 1'b1;
      next_cycles(3);
      check_leds(virt, 1'b0);
      @(negedge clk21m);
      if (virt)
         vsd_miso = 1'b1;
      else
         sd_miso = 1'b1;
      next_cycles(3);
      check_leds(virt, 1'b1);
   endtask

   task automatic test_ddr_sharing();
      for (int i = 0; i < 16; i++) begin
         @(negedge clk21m);
         ddr_dl.addr  = 28'(rand_value(28));
         ddr_dl.rd    = 1'(rand_value(1));
         ddr_cas.addr = 28'(rand_value(28));
         ddr_cas.rd   = 1'(rand_value(1));
         dl_request   = 1'(rand_value(1));
         ddr_ready    = 1'(rand_value(1));
         #5;
         check("ddr_req.addr", 64'(ddr_req.addr), dl_request ? 64'(ddr_dl.addr) :
               64'(ddr_cas.addr));
         check("ddr_req.rd", 64'(ddr_req.rd), dl_request ? 64'(ddr_dl.rd) : 64'(ddr_cas.rd));
         check("dl_ready", 64'(dl_ready), 64'(ddr_ready));
         check("cas_ready", 64'(cas_ready), 64'(ddr_ready));
      end
   endtask

   task automatic test_audio_source();
      for (int i = 0; i < 16; i++) begin
         @(negedge clk21m);
         cas_src    = i[0] ? CAS_SRC_ADC : CAS_SRC_FILE;
         cas_dout   = i[1];
         adc_dout   = i[2];
         adc_active = i[3];
         #5;
         check("cas_audio", 64'(cas_audio), i[0] ? 64'(i[2] & i[3]) : 64'(i[1]));
      end
   endtask

   // ======================================================================
   // Main sequence
   // ======================================================================
   initial begin
      rst                = 1'b1;
      video_settings     = '0;
      forced_scandoubler = 1'b0;
      hdmi_width         = '0;
      hdmi_height        = '0;
      spi_master         = '0;
      sd_miso            = 1'b0;
      vsd_miso           = 1'b0;
      vsd_mounted        = 1'b0;
      vsd_size           = '0;
      ioctl_download     = 1'b0;
      ioctl_index        = '0;
      tape_rewind_req    = 1'b0;
      motor              = 1'b0;
      cas_src            = CAS_SRC_FILE;
      cas_dout           = 1'b0;
      adc_dout           = 1'b0;
      adc_active         = 1'b0;
      ddr_dl             = '0;
      dl_request         = 1'b0;
      ddr_cas            = '0;
      ddr_ready          = 1'b0;

      next_cycles(10);
      // Reset also rewinds the tape
      check("rewind", 64'(rewind), 64'd1);
      rst = 1'b0;

      test_cassette();
      test_crop_table();
      test_aspect_fields();
      test_sd_routing();
      test_activity_led(1'b0);
      test_activity_led(1'b1);
      test_ddr_sharing();
      test_audio_source();

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+hdl
hdl/msx_video_pkg.sv
hdl/msx_media_pkg.sv
hdl/video_crop_ctrl.sv
hdl/sd_route.sv
hdl/cas_ctrl.sv
hdl/msx_glue_top.sv
tests/tb_msx_glue.sv
